// File: source/spi_flash_pkg.sv
// Constants, opcodes and structs shared by the SPI flash read path.
// Only SPI mode 0 with one MOSI and one MISO line is covered.
// SCK runs at half the clk rate, so one byte takes HALF_PERIODS cycles.
package spi_flash_pkg;

	localparam int ADDR_W = 24;
	localparam int WORD_W = 32;
	localparam int BYTE_W = 8;
	localparam int HALF_PERIODS = 16;
	// Extra clk cycles that csb stays high between commands.
	localparam int CS_GAP = 2;
	localparam logic [BYTE_W-1:0] DUMMY_BYTE = 8'h00;

	typedef enum logic [BYTE_W-1:0] {
		OP_READ       = 8'h03,
		OP_WAKE       = 8'hAB,
		OP_RESET_CONT = 8'hFF
	} flash_op_e;

	typedef enum logic [3:0] {
		S_RESET_CONT,
		S_WAKE,
		S_CMD,
		S_IDLE,
		S_ADDR_HI,
		S_ADDR_MID,
		S_ADDR_LO,
		S_DATA,
		S_HOLD
	} seq_state_e;

	// Pins driven toward the flash.
	typedef struct packed {
		logic csb;
		logic sck;
		logic mosi;
	} flash_pins_t;

	// One byte request from the sequencer, start is a single cycle pulse.
	typedef struct packed {
		logic              start;
		logic [BYTE_W-1:0] tx_data;
		logic              capture;
	} byte_cmd_t;

endpackage

// File: source/flash_read_sequencer.sv
// Byte level FSM of the flash reader.
// Wakes the flash once after reset, then opens read commands on demand.
// A request that misses is only acted on in S_IDLE or S_HOLD, so a byte
// already on the wire always completes before csb is raised.
`timescale 1ns/10ps

module flash_read_sequencer import spi_flash_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  logic              valid,
	input  logic [ADDR_W-1:0] addr,
	input  logic              hit,
	input  logic              next_hit,
	input  logic              word_valid,
	input  logic              byte_done,
	input  logic              busy,
	output byte_cmd_t         byte_cmd,
	output logic              csb,
	output logic              restart
);

	seq_state_e        state;
	logic              sent;
	logic [1:0]        gap;
	logic [1:0]        data_cnt;
	logic              want;
	logic [BYTE_W-1:0] tx_next;
	logic              cap_next;
	logic              issue;
	logic              miss;
	logic              cs_close;

	//--------------------------------------------------------------------------
	// Byte to send in each state.
	//--------------------------------------------------------------------------
	always_comb begin
		want = 1'b0;
		tx_next = DUMMY_BYTE;
		cap_next = 1'b0;
		case (state)
			S_RESET_CONT: begin
				want = 1'b1;
				tx_next = OP_RESET_CONT;
			end
			S_WAKE: begin
				want = 1'b1;
				tx_next = OP_WAKE;
			end
			S_CMD: begin
				want = 1'b1;
				tx_next = OP_READ;
			end
			S_ADDR_HI: begin
				want = 1'b1;
				tx_next = addr[23:16];
			end
			S_ADDR_MID: begin
				want = 1'b1;
				tx_next = addr[15:8];
			end
			S_ADDR_LO: begin
				want = 1'b1;
				tx_next = addr[7:0];
			end
			S_DATA: begin
				want = 1'b1;
				cap_next = 1'b1;
			end
			default: want = 1'b0;
		endcase
	end

	// One byte per state visit, and never inside the csb gap.
	assign issue = want && !sent && (gap == '0) && !busy;
	assign miss = (state == S_HOLD) && valid && !hit && !next_hit;
	// The wake opcodes each stand alone, framed by their own csb pulse.
	assign cs_close = miss || (byte_done && (state == S_RESET_CONT || state == S_WAKE));

	//--------------------------------------------------------------------------
	// State register, csb and byte requests.
	//--------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_RESET_CONT;
			byte_cmd <= '0;
			csb <= 1'b1;
			restart <= 1'b0;
			gap <= '0;
			sent <= 1'b0;
			data_cnt <= '0;
		end else begin
			byte_cmd.start <= 1'b0;
			restart <= miss;
			if (byte_done) begin
				sent <= 1'b0;
			end
			if (cs_close) begin
				csb <= 1'b1;
				gap <= 2'(CS_GAP);
			end else if (gap != '0) begin
				gap <= gap - 2'd1;
			end
			if (issue) begin
				byte_cmd <= '{start: 1'b1, tx_data: tx_next, capture: cap_next};
				csb <= 1'b0;
				sent <= 1'b1;
			end

			case (state)
				S_RESET_CONT: if (byte_done) state <= S_WAKE;
				S_WAKE:       if (byte_done) state <= S_CMD;
				S_CMD:        if (byte_done) state <= S_IDLE;
				// Opcode is out and csb stays low until an address shows up.
				S_IDLE:       if (valid) state <= S_ADDR_HI;
				S_ADDR_HI:    if (byte_done) state <= S_ADDR_MID;
				S_ADDR_MID:   if (byte_done) state <= S_ADDR_LO;
				S_ADDR_LO: begin
					if (byte_done) begin
						data_cnt <= '0;
						state <= S_DATA;
					end
				end
				S_DATA: begin
					if (byte_done) begin
						data_cnt <= data_cnt + 2'd1;
						// Prefetch stops one byte short so the served word stays put.
						if (data_cnt == 2'd2 && word_valid) begin
							state <= S_HOLD;
						end
					end
				end
				S_HOLD: begin
					if (valid) begin
						if (hit || next_hit) begin
							state <= S_DATA;
						end else begin
							state <= S_CMD;
						end
					end
				end
				default: state <= S_RESET_CONT;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (!resetn) byte_cmd.start |-> !busy)
		else $error("byte start while the bit timer is busy");

	// The flash needs csb high between the old and the new command.
	assert property (@(posedge clk) disable iff (!resetn) restart |-> csb [*CS_GAP])
		else $error("csb not raised on restart");

endmodule

// File: source/spi_bit_timer.sv
// Times one SPI byte as 16 half periods of SCK.
// SCK is low in even half periods and high in odd ones (mode 0).
// Held idle while csb is high.
`timescale 1ns/10ps

module spi_bit_timer import spi_flash_pkg::*; (
	input  logic clk,
	input  logic resetn,
	input  logic start,
	input  logic csb,
	output logic sck,
	output logic busy,
	output logic byte_done,
	output logic sample,
	output logic shift
);

	logic [$clog2(HALF_PERIODS)-1:0] half_cnt;
	logic                            active;

	always_ff @(posedge clk) begin
		if (!resetn || csb) begin
			active <= 1'b0;
			half_cnt <= '0;
		end else if (start) begin
			active <= 1'b1;
			half_cnt <= '0;
		end else if (active) begin
			if (half_cnt == HALF_PERIODS - 1) begin
				active <= 1'b0;
			end
			half_cnt <= half_cnt + 1'b1;
		end
	end

	assign busy = active;
	assign sck = active && half_cnt[0];
	// SCK rises at the end of an even half period, falls at the end of an odd one.
	assign sample = active && !half_cnt[0];
	assign shift = active && half_cnt[0];
	assign byte_done = active && (half_cnt == HALF_PERIODS - 1);

	assert property (@(posedge clk) disable iff (!resetn)
		start |-> !byte_done [*HALF_PERIODS] ##1 byte_done)
		else $error("byte_done not exactly 16 cycles after start");

endmodule

// File: source/spi_byte_shifter.sv
// Transmit and receive shift registers for one SPI byte, MSB first.
// rx_byte holds the full byte from the cycle of byte_done until the next
// byte starts sampling.
`timescale 1ns/10ps

module spi_byte_shifter import spi_flash_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  byte_cmd_t         byte_cmd,
	input  logic              sample,
	input  logic              shift,
	input  logic              miso,
	output logic              mosi,
	output logic [BYTE_W-1:0] rx_byte
);

	logic [BYTE_W-1:0] tx_reg;
	logic [BYTE_W-1:0] rx_reg;

	// Transmit side.
	// The new byte is loaded before the first rising SCK edge.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			tx_reg <= '0;
		end else if (byte_cmd.start) begin
			tx_reg <= byte_cmd.tx_data;
		end else if (shift) begin
			tx_reg <= {tx_reg[BYTE_W-2:0], 1'b0};
		end
	end

	// Receive side.
	// Eight samples flush whatever was left from the previous byte.
	always_ff @(posedge clk) begin
		if (sample) begin
			rx_reg <= {rx_reg[BYTE_W-2:0], miso};
		end
	end

	assign mosi = tx_reg[BYTE_W-1];
	assign rx_byte = rx_reg;

endmodule

// File: source/prefetch_word_buffer.sv
// Builds 32-bit words from captured flash bytes, lowest address in the
// low byte. Holds one delivered word and its byte address.
// Bus addresses are expected to be word aligned.
`timescale 1ns/10ps

module prefetch_word_buffer import spi_flash_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  logic              capture,
	input  logic              byte_done,
	input  logic [BYTE_W-1:0] rx_byte,
	input  logic              restart,
	input  logic [ADDR_W-1:0] cmd_addr,
	input  logic              valid,
	input  logic [ADDR_W-1:0] addr,
	output logic [WORD_W-1:0] rdata,
	output logic              word_valid,
	output logic              hit,
	output logic              next_hit
);

	logic [1:0]               lane;
	logic                     first_word;
	logic [WORD_W-BYTE_W-1:0] partial;
	logic [ADDR_W-1:0]        word_addr;
	logic [ADDR_W-1:0]        next_addr;
	logic                     take;

	assign take = byte_done && capture;
	assign next_addr = word_addr + ADDR_W'(4);

	// Lane counter and word status.
	always_ff @(posedge clk) begin
		if (!resetn || restart) begin
			lane <= '0;
			word_valid <= 1'b0;
			first_word <= 1'b1;
		end else if (take) begin
			lane <= lane + 2'd1;
			if (lane == 2'd3) begin
				word_valid <= 1'b1;
				first_word <= 1'b0;
			end
		end
	end

	// Data path.
	// Within one command the words follow each other by 4 bytes.
	always_ff @(posedge clk) begin
		if (take) begin
			if (lane != 2'd3) begin
				partial[lane*BYTE_W +: BYTE_W] <= rx_byte;
			end else begin
				rdata <= {rx_byte, partial};
				word_addr <= first_word ? cmd_addr : next_addr;
			end
		end
	end

	assign hit = valid && word_valid && (addr == word_addr);
	assign next_hit = valid && word_valid && (addr == next_addr);

	assert property (@(posedge clk) disable iff (!resetn) word_valid |-> word_addr[1:0] == 2'b00)
		else $error("buffered word address not word aligned");

endmodule

// File: source/spi_flash_reader.sv
// Read-only SPI flash controller with a one word prefetch.
// Bus side: hold valid and addr until ready, addr word aligned.
// ready is combinational from valid and addr.
`timescale 1ns/10ps

module spi_flash_reader import spi_flash_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  logic              valid,
	input  logic [ADDR_W-1:0] addr,
	output logic              ready,
	output logic [WORD_W-1:0] rdata,
	output flash_pins_t       pins,
	input  logic              miso
);

	byte_cmd_t         byte_cmd;
	logic              csb;
	logic              restart;
	logic              hit;
	logic              next_hit;
	logic              word_valid;
	logic              byte_done;
	logic              busy;
	logic              sample;
	logic              shift;
	logic              sck;
	logic              mosi;
	logic [BYTE_W-1:0] rx_byte;

	flash_read_sequencer sequencer_i (
		.clk        (clk),
		.resetn     (resetn),
		.valid      (valid),
		.addr       (addr),
		.hit        (hit),
		.next_hit   (next_hit),
		.word_valid (word_valid),
		.byte_done  (byte_done),
		.busy       (busy),
		.byte_cmd   (byte_cmd),
		.csb        (csb),
		.restart    (restart)
	);

	spi_bit_timer timer_i (
		.clk       (clk),
		.resetn    (resetn),
		.start     (byte_cmd.start),
		.csb       (csb),
		.sck       (sck),
		.busy      (busy),
		.byte_done (byte_done),
		.sample    (sample),
		.shift     (shift)
	);

	spi_byte_shifter shifter_i (
		.clk      (clk),
		.resetn   (resetn),
		.byte_cmd (byte_cmd),
		.sample   (sample),
		.shift    (shift),
		.miso     (miso),
		.mosi     (mosi),
		.rx_byte  (rx_byte)
	);

	// The first word of a command lands while the bus still holds its address.
	prefetch_word_buffer buffer_i (
		.clk        (clk),
		.resetn     (resetn),
		.capture    (byte_cmd.capture),
		.byte_done  (byte_done),
		.rx_byte    (rx_byte),
		.restart    (restart),
		.cmd_addr   (addr),
		.valid      (valid),
		.addr       (addr),
		.rdata      (rdata),
		.word_valid (word_valid),
		.hit        (hit),
		.next_hit   (next_hit)
	);

	assign ready = hit;
	assign pins.csb = csb;
	assign pins.sck = sck;
	assign pins.mosi = mosi;

endmodule

// File: bench/spi_flash_model.sv
// Behavioral serial NOR flash, SPI mode 0, single I/O.
// Byte at address a is a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A.
// Reads stream on past the end of the 24-bit space by wrapping to zero.
`timescale 1ns/10ps

module spi_flash_model import spi_flash_pkg::*; (
	input  flash_pins_t pins,
	output logic        miso,
	output int          read_starts,
	output logic        model_error
);

	logic [BYTE_W-1:0] shift_in;
	logic [BYTE_W-1:0] opcode;
	logic [ADDR_W-1:0] rd_addr;
	logic              reset_seen;
	logic              awake;
	int                bit_cnt;

	function automatic logic [BYTE_W-1:0] byte_at(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
	endfunction

	initial begin
		miso = 1'b0;
		read_starts = 0;
		model_error = 1'b0;
		reset_seen = 1'b0;
		awake = 1'b0;
		bit_cnt = 0;
		opcode = '0;
		shift_in = '0;
		rd_addr = '0;
	end

	// Every csb high ends the current frame.
	always @(posedge pins.csb) begin
		bit_cnt = 0;
		opcode = '0;
	end

	//----------------------------------------------------------------------------
	// Command decode on rising SCK.
	//----------------------------------------------------------------------------
	always @(posedge pins.sck) begin
		if (!pins.csb) begin
			shift_in = {shift_in[BYTE_W-2:0], pins.mosi};
			bit_cnt = bit_cnt + 1;
			if (bit_cnt == 8) begin
				opcode = shift_in;
				case (shift_in)
					OP_RESET_CONT: reset_seen = 1'b1;
					OP_WAKE: begin
						if (!reset_seen) model_error = 1'b1;
						awake = 1'b1;
					end
					OP_READ: begin
						if (!awake) model_error = 1'b1;
						read_starts = read_starts + 1;
					end
					default: model_error = 1'b1;
				endcase
			end else if (opcode == OP_READ && bit_cnt <= 32 && bit_cnt % 8 == 0) begin
				rd_addr = {rd_addr[ADDR_W-BYTE_W-1:0], shift_in};
			end
		end
	end

	// Data goes out on falling SCK, MSB first, once the address is complete.
	always @(negedge pins.sck) begin
		logic [BYTE_W-1:0] data;
		int                k;
		if (!pins.csb && opcode == OP_READ && bit_cnt >= 32) begin
			k = bit_cnt - 32;
			data = byte_at(rd_addr + ADDR_W'(k / 8));
			miso <= data[7 - (k % 8)];
		end
	end

endmodule

// File: bench/tb_spi_flash_reader.sv
// Table-driven testbench for the SPI flash reader with a flash model.
// Requests are held until ready, one at a time.
// Random addresses come from a 16-bit Fibonacci LFSR with a fixed seed.
`timescale 1ns/10ps

module tb_spi_flash_reader import spi_flash_pkg::*; ();

	localparam int NUM_FIXED = 11;
	localparam int NUM_RANDOM = 9;
	localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
	localparam int RESET_CYCLES = 4;
	localparam int IDLE_CYCLES = 100;
	localparam int WAKE_CYCLES = RESET_CYCLES + 3 * (HALF_PERIODS + 4);
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 200 + WAKE_CYCLES + 2 * IDLE_CYCLES;
	localparam logic [15:0] LFSR_SEED = 16'd13754;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              restart;
		logic              idle;
		logic              same_cycle;
	} entry_t;

	logic              clk;
	logic              resetn;
	logic              valid;
	logic [ADDR_W-1:0] addr;
	logic              ready;
	logic [WORD_W-1:0] rdata;
	flash_pins_t       pins;
	logic              miso;
	int                read_starts;
	logic              model_error;
	entry_t            stim_table [NUM_ENTRIES];
	int                errors;
	int                checks;
	int                expected_starts;
	int                cycle_cnt;

	spi_flash_reader spi_flash_reader_i (
		.clk    (clk),
		.resetn (resetn),
		.valid  (valid),
		.addr   (addr),
		.ready  (ready),
		.rdata  (rdata),
		.pins   (pins),
		.miso   (miso)
	);

	spi_flash_model flash_i (
		.pins        (pins),
		.miso        (miso),
		.read_starts (read_starts),
		.model_error (model_error)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Watchdog.
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//----------------------------------------------------------------------------
	// Reference data and random source.
	//----------------------------------------------------------------------------
	function automatic logic [BYTE_W-1:0] flash_byte(input logic [ADDR_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ 8'h5A;
	endfunction

	// Lowest address lands in the low byte.
	function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] a);
		return {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1),
			flash_byte(a)};
	endfunction

	// Taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	//----------------------------------------------------------------------------
	// Compare tasks.
	//----------------------------------------------------------------------------
	task automatic check_word(input string name, input logic [WORD_W-1:0] got,
			input logic [WORD_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_pins(input flash_pins_t got, input flash_pins_t exp);
		checks++;
		if (got.csb !== exp.csb) begin
			errors++;
			$display("Mismatch at %0t ns: pins.csb got %b expected %b", $time, got.csb, exp.csb);
		end
		if (got.sck !== exp.sck) begin
			errors++;
			$display("Mismatch at %0t ns: pins.sck got %b expected %b", $time, got.sck, exp.sck);
		end
		if (got.mosi !== exp.mosi) begin
			errors++;
			$display("Mismatch at %0t ns: pins.mosi got %b expected %b", $time, got.mosi,
				exp.mosi);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	//----------------------------------------------------------------------------
	// Stimulus table.
	//----------------------------------------------------------------------------
	task automatic build_table();
		logic [15:0]       lfsr;
		logic [21:0]       rnd;
		logic [ADDR_W-1:0] prev;
		lfsr = LFSR_SEED;
		stim_table[0] = '{24'h000100, 1'b1, 1'b0, 1'b0};
		stim_table[1] = '{24'h000104, 1'b0, 1'b0, 1'b0};
		stim_table[2] = '{24'h000108, 1'b0, 1'b0, 1'b0};
		// Same word again, served from the buffer.
		stim_table[3] = '{24'h000108, 1'b0, 1'b0, 1'b1};
		stim_table[4] = '{24'h00010C, 1'b0, 1'b0, 1'b0};
		stim_table[5] = '{24'h000110, 1'b0, 1'b1, 1'b0};
		stim_table[6] = '{24'h0A0000, 1'b1, 1'b0, 1'b0};
		stim_table[7] = '{24'h0A0004, 1'b0, 1'b0, 1'b0};
		stim_table[8] = '{24'hFFFFF8, 1'b1, 1'b0, 1'b0};
		stim_table[9] = '{24'hFFFFFC, 1'b0, 1'b0, 1'b0};
		// Stream wraps at the top of the flash.
		stim_table[10] = '{24'h000000, 1'b0, 1'b0, 1'b0};
		for (int i = NUM_FIXED; i < NUM_ENTRIES; i++) begin
			prev = stim_table[i-1].addr;
			if ((i - NUM_FIXED) % 3 == 2) begin
				stim_table[i] = '{prev + 24'd4, 1'b0, 1'b0, 1'b0};
			end else begin
				for (int b = 0; b < 22; b++) begin
					lfsr = lfsr_next(lfsr);
					rnd = {rnd[20:0], lfsr[0]};
				end
				stim_table[i] = '{{rnd, 2'b00}, 1'b1, 1'b0, 1'b0};
				// A jump must not land on the buffered or prefetched words.
				if (stim_table[i].addr - prev <= 24'd8) begin
					stim_table[i].addr[12] = ~stim_table[i].addr[12];
				end
			end
		end
	endtask

	// SCK stays quiet while the bus idles after the prefetch.
	task automatic idle_hold();
		repeat (IDLE_CYCLES) @(posedge clk);
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check_pins(pins, '{csb: 1'b0, sck: 1'b0, mosi: 1'b0});
		end
	endtask

	task automatic run_entry(input int idx);
		entry_t            e;
		logic [WORD_W-1:0] got;
		int                wait_cycles;
		int                err_before;
		e = stim_table[idx];
		err_before = errors;
		if (e.idle) idle_hold();
		@(posedge clk);
		#1;
		valid = 1'b1;
		addr = e.addr;
		wait_cycles = 0;
		@(negedge clk);
		while (!ready) begin
			wait_cycles++;
			@(negedge clk);
		end
		got = rdata;
		@(posedge clk);
		#1;
		valid = 1'b0;
		if (e.same_cycle && wait_cycles != 0) begin
			errors++;
			$display("ready for a buffered address came %0d cycles late", wait_cycles);
		end
		check_word("rdata", got, expected_word(e.addr));
		expected_starts += e.restart;
		check_count("read_starts", read_starts, expected_starts);
		$display("test %0d addr %06h: %s after %0d cycles", idx, e.addr,
			(errors == err_before) ? "ok" : "failed", wait_cycles);
	endtask

	initial begin
		resetn = 1'b0;
		valid = 1'b0;
		addr = '0;
		errors = 0;
		checks = 0;
		expected_starts = 0;
		cycle_cnt = 0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		resetn = 1'b1;
		// Reset state, before the first byte goes out.
		@(negedge clk);
		check_pins(pins, '{csb: 1'b1, sck: 1'b0, mosi: 1'b0});
		check_bit("ready", ready, 1'b0);
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			run_entry(i);
		end
		check_bit("model_error", model_error, 1'b0);
		$display("%0d tests, %0d checks, %0d errors", NUM_ENTRIES, checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: sim.f
source/spi_flash_pkg.sv
source/flash_read_sequencer.sv
source/spi_bit_timer.sv
source/spi_byte_shifter.sv
source/prefetch_word_buffer.sv
source/spi_flash_reader.sv
bench/spi_flash_model.sv
bench/tb_spi_flash_reader.sv
